// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = fpu_div_tb
FILELIST = all.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
hw/fpu_div_pkg.sv
hw/fpu_operand_if.sv
hw/fpu_quotient_if.sv
hw/fpu_div_classify.sv
hw/fpu_div_mantissa.sv
hw/fpu_div_round.sv
hw/fpu_div.sv
verification/fpu_div_assert.sv
verification/fpu_div_tb.sv

// ==== hw/fpu_div.sv ====
`timescale 1ns/10ps

module fpu_div (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_request,
	input  fpu_div_pkg::float_t i_op1,
	input  fpu_div_pkg::float_t i_op2,
	output logic                o_ready,
	output fpu_div_pkg::float_t o_result
);
	import fpu_div_pkg::*;

	logic special_valid;
	float_t special_word;

	fpu_operand_if operand_bus ();
	fpu_quotient_if quotient_bus ();

	// operand capture and special cases
	fpu_div_classify u_classify (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_request       (i_request),
		.i_op1           (i_op1),
		.i_op2           (i_op2),
		.o_special_valid (special_valid),
		.o_special_word  (special_word),
		.operand         (operand_bus.producer)
	);

	fpu_div_mantissa u_mantissa (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.operand  (operand_bus.consumer),
		.quotient (quotient_bus.producer)
	);

	// result select, rounding and the output handshake
	fpu_div_round u_round (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_request       (i_request),
		.i_special_valid (special_valid),
		.i_special_word  (special_word),
		.quotient        (quotient_bus.consumer),
		.o_ready         (o_ready),
		.o_result        (o_result)
	);

endmodule

// ==== hw/fpu_div_classify.sv ====
`timescale 1ns/10ps

module fpu_div_classify (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_request,
	input  fpu_div_pkg::float_t i_op1,
	input  fpu_div_pkg::float_t i_op2,
	output logic                o_special_valid,
	output fpu_div_pkg::float_t o_special_word,
	fpu_operand_if.producer     operand
);
	import fpu_div_pkg::*;

	logic armed;
	logic pending;
	float_t op_a;
	float_t op_b;
	class_t class_a;
	class_t class_b;
	logic sign_z;
	logic special;
	float_t special_word;

	function automatic class_t classify(input float_t op);
		logic [EXP_WIDTH-1:0] field;
		logic [MANT_WIDTH-1:0] frac;
		field = op[MANT_WIDTH +: EXP_WIDTH];
		frac = op[MANT_WIDTH-1:0];
		if (field == EXP_ALL_ONES) begin
			return (frac != '0) ? CLASS_NAN : CLASS_INFINITY;
		end
		if (field == EXP_ZERO) begin
			return (frac != '0) ? CLASS_DENORMAL : CLASS_ZERO;
		end
		return CLASS_NORMAL;
	endfunction

	// denormals sit at the minimum exponent without a hidden bit
	function automatic exp_t unbias(input float_t op);
		logic [EXP_WIDTH-1:0] field;
		field = op[MANT_WIDTH +: EXP_WIDTH];
		if (field == EXP_ZERO) begin
			return EXP_MIN;
		end
		return exp_t'(field) - exp_t'(EXP_BIAS);
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			armed <= 1'b1;
			pending <= 1'b0;
		end else begin
			pending <= 1'b0;
			if (!i_request) begin
				armed <= 1'b1;
			end else if (armed) begin
				armed <= 1'b0;
				pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_request && armed) begin
			op_a <= i_op1;
			op_b <= i_op2;
		end
	end

	assign class_a = classify(op_a);
	assign class_b = classify(op_b);
	assign sign_z = op_a[31] ^ op_b[31];

	// priority follows the order of the checks
	always_comb begin
		special = 1'b1;
		special_word = QNAN_WORD;
		if (class_a == CLASS_NAN || class_b == CLASS_NAN ||
				(class_a == CLASS_INFINITY && class_b == CLASS_INFINITY) ||
				(class_a == CLASS_ZERO && class_b == CLASS_ZERO)) begin
			special_word = QNAN_WORD;
		end else if (class_a == CLASS_INFINITY) begin
			special_word = {sign_z, EXP_ALL_ONES, {MANT_WIDTH{1'b0}}};
		end else if (class_b == CLASS_INFINITY || class_a == CLASS_ZERO) begin
			special_word = {sign_z, EXP_ZERO, {MANT_WIDTH{1'b0}}};
		end else if (class_b == CLASS_ZERO) begin
			special_word = {sign_z, EXP_ALL_ONES, {MANT_WIDTH{1'b0}}};
		end else begin
			special = 1'b0;
		end
	end

	assign o_special_valid = pending & special;
	assign o_special_word = special_word;

	assign operand.start = pending & ~special;
	assign operand.sign_a = op_a[31];
	assign operand.sign_b = op_b[31];
	assign operand.exp_a = unbias(op_a);
	assign operand.exp_b = unbias(op_b);
	assign operand.sig_a = {class_a != CLASS_DENORMAL, op_a[MANT_WIDTH-1:0]};
	assign operand.sig_b = {class_b != CLASS_DENORMAL, op_b[MANT_WIDTH-1:0]};

endmodule

// ==== hw/fpu_div_mantissa.sv ====
`timescale 1ns/10ps

module fpu_div_mantissa (
	input logic              i_clock,
	input logic              i_reset,
	fpu_operand_if.consumer  operand,
	fpu_quotient_if.producer quotient
);
	import fpu_div_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_NORM,
		ST_SHIFT,
		ST_SUB
	} state_t;

	state_t state;
	logic done;
	logic [$clog2(DIV_STEPS)-1:0] count;
	logic sign_z;
	exp_t exp_a;
	exp_t exp_b;
	exp_t exp_z;
	logic [SIG_WIDTH-1:0] sig_a;
	logic [SIG_WIDTH-1:0] sig_b;
	logic [SIG_WIDTH+QUOT_WIDTH-1:0] dividend;
	logic [SIG_WIDTH:0] remainder;
	logic [QUOT_WIDTH-1:0] quot;
	logic last_step;
	logic norm_done;

	assign last_step = (count == ($clog2(DIV_STEPS))'(DIV_STEPS - 1));
	assign norm_done = sig_a[SIG_WIDTH-1] & sig_b[SIG_WIDTH-1];

	// a new start always restarts the division
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (operand.start) begin
				state <= ST_NORM;
			end else begin
				case (state)
					ST_NORM: begin
						if (norm_done) begin
							count <= '0;
							state <= ST_SHIFT;
						end
					end
					ST_SHIFT: begin
						state <= ST_SUB;
					end
					ST_SUB: begin
						if (last_step) begin
							done <= 1'b1;
							state <= ST_IDLE;
						end else begin
							count <= count + 1'b1;
							state <= ST_SHIFT;
						end
					end
					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (operand.start) begin
			sign_z <= operand.sign_a ^ operand.sign_b;
			exp_a <= operand.exp_a;
			exp_b <= operand.exp_b;
			sig_a <= operand.sig_a;
			sig_b <= operand.sig_b;
		end else begin
			case (state)
				ST_NORM: begin
					// one shift per cycle with the dividend first
					if (!sig_a[SIG_WIDTH-1]) begin
						sig_a <= sig_a << 1;
						exp_a <= exp_a - exp_t'(1);
					end else if (!sig_b[SIG_WIDTH-1]) begin
						sig_b <= sig_b << 1;
						exp_b <= exp_b - exp_t'(1);
					end else begin
						exp_z <= exp_a - exp_b;
						dividend <= {sig_a, {QUOT_WIDTH{1'b0}}};
						remainder <= '0;
						quot <= '0;
					end
				end
				ST_SHIFT: begin
					quot <= quot << 1;
					remainder <= {remainder[SIG_WIDTH-1:0], dividend[SIG_WIDTH+QUOT_WIDTH-1]};
					dividend <= dividend << 1;
				end
				ST_SUB: begin
					if (remainder >= {1'b0, sig_b}) begin
						quot[0] <= 1'b1;
						remainder <= remainder - {1'b0, sig_b};
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign quotient.valid = done;
	assign quotient.sign = sign_z;
	assign quotient.exp = exp_z;
	assign quotient.sig = quot[QUOT_WIDTH-1 -: SIG_WIDTH];
	assign quotient.guard = quot[2];
	assign quotient.round_bit = quot[1];
	// lowest quotient bit and any remainder both count as sticky
	assign quotient.sticky = quot[0] | (remainder != '0);

endmodule

// ==== hw/fpu_div_pkg.sv ====
package fpu_div_pkg;

	// ieee-754 single precision word
	typedef logic [31:0] float_t;

	localparam int EXP_WIDTH = 8;
	localparam int MANT_WIDTH = 23;
	localparam int SIG_WIDTH = MANT_WIDTH + 1;
	localparam int EXP_BIAS = 127;

	// unbiased exponent, wide enough for a difference of two normalised exponents
	typedef logic signed [9:0] exp_t;

	localparam exp_t EXP_MIN = exp_t'(1 - EXP_BIAS);
	localparam exp_t EXP_MAX = exp_t'(EXP_BIAS);

	// 24 significand bits, guard, round and one spare
	localparam int QUOT_WIDTH = SIG_WIDTH + 3;
	localparam int DIV_STEPS = 50;

	localparam logic [EXP_WIDTH-1:0] EXP_ALL_ONES = '1;
	localparam logic [EXP_WIDTH-1:0] EXP_ZERO = '0;

	// the only NaN the unit ever returns
	localparam float_t QNAN_WORD = 32'hffc00000;

	typedef enum logic [2:0] {
		CLASS_ZERO,
		CLASS_DENORMAL,
		CLASS_NORMAL,
		CLASS_INFINITY,
		CLASS_NAN
	} class_t;

endpackage

// ==== hw/fpu_div_round.sv ====
`timescale 1ns/10ps

module fpu_div_round (
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_request,
	input  logic                i_special_valid,
	input  fpu_div_pkg::float_t i_special_word,
	fpu_quotient_if.consumer    quotient,
	output logic                o_ready,
	output fpu_div_pkg::float_t o_result
);
	import fpu_div_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_NORM_LEFT,
		ST_NORM_RIGHT,
		ST_ROUND,
		ST_PACK,
		ST_HOLD
	} state_t;

	state_t state;
	logic z_s;
	exp_t z_e;
	logic [SIG_WIDTH-1:0] z_m;
	logic guard;
	logic round_bit;
	logic sticky;
	logic shift_left;
	logic shift_right;
	logic [EXP_WIDTH-1:0] exp_field;
	float_t result_word;

	assign shift_left = !z_m[SIG_WIDTH-1] && (z_e > EXP_MIN);
	assign shift_right = (z_e < EXP_MIN);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_ready <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_special_valid) begin
						o_ready <= 1'b1;
						state <= ST_HOLD;
					end else if (quotient.valid) begin
						state <= ST_NORM_LEFT;
					end
				end
				ST_NORM_LEFT: begin
					if (!shift_left) begin
						state <= ST_NORM_RIGHT;
					end
				end
				ST_NORM_RIGHT: begin
					if (!shift_right) begin
						state <= ST_ROUND;
					end
				end
				ST_ROUND: begin
					state <= ST_PACK;
				end
				ST_PACK: begin
					o_ready <= 1'b1;
					state <= ST_HOLD;
				end
				ST_HOLD: begin
					if (!i_request) begin
						o_ready <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		case (state)
			ST_IDLE: begin
				if (i_special_valid) begin
					o_result <= i_special_word;
				end else if (quotient.valid) begin
					z_s <= quotient.sign;
					z_e <= quotient.exp;
					z_m <= quotient.sig;
					guard <= quotient.guard;
					round_bit <= quotient.round_bit;
					sticky <= quotient.sticky;
				end
			end
			ST_NORM_LEFT: begin
				if (shift_left) begin
					z_e <= z_e - exp_t'(1);
					z_m <= {z_m[SIG_WIDTH-2:0], guard};
					guard <= round_bit;
					round_bit <= 1'b0;
				end
			end
			ST_NORM_RIGHT: begin
				// in the denormal range the bits fall into guard and sticky
				if (shift_right) begin
					z_e <= z_e + exp_t'(1);
					z_m <= z_m >> 1;
					guard <= z_m[0];
					round_bit <= guard;
					sticky <= sticky | round_bit;
				end
			end
			ST_ROUND: begin
				if (guard && (round_bit || sticky || z_m[0])) begin
					z_m <= z_m + 1'b1;
					if (&z_m) begin
						z_e <= z_e + exp_t'(1);
					end
				end
			end
			ST_PACK: begin
				o_result <= result_word;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		exp_field = EXP_WIDTH'(z_e + EXP_BIAS);
		if (z_e == EXP_MIN && !z_m[SIG_WIDTH-1]) begin
			exp_field = EXP_ZERO;
		end
		result_word = {z_s, exp_field, z_m[MANT_WIDTH-1:0]};
		// overflow saturates to infinity
		if (z_e > EXP_MAX) begin
			result_word = {z_s, EXP_ALL_ONES, {MANT_WIDTH{1'b0}}};
		end
	end

endmodule

// ==== hw/fpu_operand_if.sv ====
`timescale 1ns/10ps

interface fpu_operand_if;
	import fpu_div_pkg::*;

	// one-cycle pulse, operands stay stable until the next one
	logic start;
	logic sign_a;
	logic sign_b;
	exp_t exp_a;
	exp_t exp_b;
	logic [SIG_WIDTH-1:0] sig_a;
	logic [SIG_WIDTH-1:0] sig_b;

	modport producer (
		output start, sign_a, sign_b, exp_a, exp_b, sig_a, sig_b
	);

	modport consumer (
		input start, sign_a, sign_b, exp_a, exp_b, sig_a, sig_b
	);

endinterface

// ==== hw/fpu_quotient_if.sv ====
`timescale 1ns/10ps

interface fpu_quotient_if;
	import fpu_div_pkg::*;

	// one-cycle pulse with the raw quotient
	logic valid;
	logic sign;
	exp_t exp;
	logic [SIG_WIDTH-1:0] sig;
	logic guard;
	logic round_bit;
	logic sticky;

	modport producer (
		output valid, sign, exp, sig, guard, round_bit, sticky
	);

	modport consumer (
		input valid, sign, exp, sig, guard, round_bit, sticky
	);

endinterface

// ==== verification/fpu_div_assert.sv ====
`timescale 1ns/10ps

module fpu_div_assert (
	input logic                i_clock,
	input logic                i_reset,
	input logic                i_request,
	input logic                o_ready,
	input fpu_div_pkg::float_t o_result
);

	ready_low_after_reset: assert property (
		@(posedge i_clock) i_reset |=> !o_ready
	) else $error("o_ready high in the cycle after reset");

	// a held request freezes the answer
	ready_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_ready && i_request) |=> (o_ready && $stable(o_result))
	) else $error("o_ready or o_result changed while the request was held");

	ready_released: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_ready && !i_request) |=> !o_ready
	) else $error("o_ready stayed high after the request dropped");

endmodule

bind fpu_div fpu_div_assert u_handshake_assert (
	.i_clock   (i_clock),
	.i_reset   (i_reset),
	.i_request (i_request),
	.o_ready   (o_ready),
	.o_result  (o_result)
);

// ==== verification/fpu_div_tb.sv ====
`timescale 1ns/10ps

module fpu_div_tb;
	import fpu_div_pkg::*;

	logic i_clock;
	logic i_reset;
	logic i_request;
	float_t i_op1;
	float_t i_op2;
	logic o_ready;
	float_t o_result;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	// op1 in the upper half, op2 in the lower half
	logic [63:0] directed [10] = '{
		64'h3f800000_40400000, 64'h7f7fffff_3f000000, 64'h00ffffff_40000000,
		64'h00000001_40000000, 64'h00000003_40000000, 64'h7f800000_7f800000,
		64'h00000000_80000000, 64'hc0000000_00000000, 64'h3f800000_ff800000,
		64'h007fffff_00000001
	};

	fpu_div fpu_div_inst (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_op1     (i_op1),
		.i_op2     (i_op2),
		.o_ready   (o_ready),
		.o_result  (o_result)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	function automatic logic is_nan(input float_t x);
		return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
	endfunction

	function automatic logic is_inf(input float_t x);
		return (x[30:23] == 8'hff) && (x[22:0] == 23'h0);
	endfunction

	function automatic logic is_zero(input float_t x);
		return x[30:0] == 31'h0;
	endfunction

	// correctly rounded quotient, nearest-even, with the unit's special cases
	function automatic float_t expected_quotient(input float_t a, input float_t b);
		logic sign;
		int ea;
		int eb;
		int e;
		int msb;
		int exp_unb;
		int shift;
		logic [127:0] ma;
		logic [127:0] mb;
		logic [127:0] q;
		logic [127:0] r;
		logic [127:0] kept;
		logic [127:0] below;
		logic guard;
		logic sticky;
		sign = a[31] ^ b[31];
		if (is_nan(a) || is_nan(b) || (is_inf(a) && is_inf(b)) || (is_zero(a) && is_zero(b)))
			return QNAN_WORD;
		if (is_inf(a))
			return {sign, 8'hff, 23'h0};
		if (is_inf(b) || is_zero(a))
			return {sign, 31'h0};
		if (is_zero(b))
			return {sign, 8'hff, 23'h0};
		ma = 128'(a[22:0]);
		ea = -126;
		if (a[30:23] != 8'h0) begin
			ma[23] = 1'b1;
			ea = int'(a[30:23]) - 127;
		end
		mb = 128'(b[22:0]);
		eb = -126;
		if (b[30:23] != 8'h0) begin
			mb[23] = 1'b1;
			eb = int'(b[30:23]) - 127;
		end
		while (!ma[23]) begin
			ma = ma << 1;
			ea--;
		end
		while (!mb[23]) begin
			mb = mb << 1;
			eb--;
		end
		e = ea - eb;
		// q carries 60 fraction bits, so its value is q * 2^(e-60)
		q = (ma << 60) / mb;
		r = (ma << 60) % mb;
		msb = q[60] ? 60 : 59;
		exp_unb = e + msb - 60;
		if (exp_unb < -126)
			exp_unb = -126;
		shift = exp_unb - 23 - (e - 60);
		if (shift > 100)
			shift = 100;
		kept = q >> shift;
		guard = q[shift-1];
		below = q & ((128'd1 << (shift - 1)) - 128'd1);
		sticky = (below != 128'd0) || (r != 128'd0);
		if (guard && (sticky || kept[0]))
			kept = kept + 128'd1;
		if (kept[24]) begin
			kept = kept >> 1;
			exp_unb++;
		end
		if (exp_unb > 127)
			return {sign, 8'hff, 23'h0};
		if (!kept[23])
			return {sign, 8'h00, kept[22:0]};
		return {sign, 8'(exp_unb + 127), kept[22:0]};
	endfunction

	function automatic float_t random_operand();
		int unsigned pick;
		logic sign;
		logic [22:0] frac;
		pick = $urandom % 16;
		sign = 1'($urandom % 2);
		frac = 23'($urandom);
		if (pick < 8)
			return {sign, 8'(1 + $urandom % 254), frac};
		if (pick < 11)
			return {sign, EXP_ZERO, frac};
		if (pick < 12)
			return {sign, 31'h0};
		if (pick < 14)
			return {sign, EXP_ALL_ONES, 23'h0};
		return {sign, EXP_ALL_ONES, frac | 23'h1};
	endfunction

	task automatic run_divide(input float_t a, input float_t b);
		float_t expected;
		float_t held;
		int cycles;
		int extra;
		expected = expected_quotient(a, b);
		@(posedge i_clock);
		i_request <= 1'b1;
		i_op1 <= a;
		i_op2 <= b;
		cycles = 0;
		@(negedge i_clock);
		while (!o_ready && cycles < 400) begin
			@(negedge i_clock);
			cycles++;
		end
		if (!o_ready) begin
			$display("timeout: no ready within 400 cycles for %h / %h", a, b);
			timeouts++;
		end else begin
			checks++;
			if (o_result !== expected) begin
				$display("error o_result: expected %h, got %h (%h / %h)",
					expected, o_result, a, b);
				errors++;
			end
			held = o_result;
			extra = $urandom % 4;
			repeat (extra) begin
				@(negedge i_clock);
				if (!o_ready || o_result !== held) begin
					$display("error o_result: held %h, got %h with o_ready %h",
						held, o_result, o_ready);
					errors++;
				end
			end
		end
		@(posedge i_clock);
		i_request <= 1'b0;
		cycles = 0;
		@(negedge i_clock);
		while (o_ready && cycles < 10) begin
			@(negedge i_clock);
			cycles++;
		end
		if (o_ready) begin
			$display("timeout: o_ready stayed high after the request dropped");
			timeouts++;
		end
	endtask

	initial begin
		float_t a;
		float_t b;
		int unsigned mode;
		void'($urandom(32'h347f));
		i_reset = 1'b1;
		i_request = 1'b0;
		i_op1 = '0;
		i_op2 = '0;
		repeat (5) @(posedge i_clock);
		i_reset <= 1'b0;
		@(negedge i_clock);
		if (o_ready !== 1'b0) begin
			$display("error o_ready: expected 0, got %h after reset", o_ready);
			errors++;
		end
		for (int i = 0; i < 10; i++) begin
			run_divide(directed[i][63:32], directed[i][31:0]);
		end
		for (int n = 0; n < 400 && timeouts == 0; n++) begin
			a = random_operand();
			b = random_operand();
			mode = $urandom % 8;
			// push the exponent difference past either end of the range
			if (mode == 0) begin
				a[30:23] = 8'(200 + $urandom % 55);
				b[30:23] = 8'(1 + $urandom % 60);
			end else if (mode == 1) begin
				a[30:23] = 8'($urandom % 40);
				b[30:23] = 8'(190 + $urandom % 64);
			end
			run_divide(a, b);
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
